//--- hw/fp_pkg.sv
// binary32 field widths, exponent limits, canonical NaN and the float word union
`default_nettype none

package fp_pkg;

  localparam int exp_w = 8;
  localparam int frac_w = 23;
  // fraction plus the hidden bit
  localparam int sig_w = 24;
  localparam int uexp_w = 10;

  localparam int bias = 127;
  localparam int emin = -126;
  localparam int emax = 127;
  localparam logic [exp_w-1:0] exp_special = 8'hff;
  localparam logic [31:0] qnan_word = 32'h7fc0_0000;

  typedef struct packed {
    logic sign;
    logic [exp_w-1:0] exponent;
    logic [frac_w-1:0] fraction;
  } float_fields_t;

  // same 32 bits seen raw or split into fields
  typedef union packed {
    logic [31:0] bits;
    float_fields_t fields;
  } float_word_t;

endpackage

`default_nettype wire

//--- hw/op_pkg.sv
// rounding mode and operation encodings, unit latency
`default_nettype none

package op_pkg;

  typedef enum logic {rne = 1'b0, rtz = 1'b1} round_mode_e;

  typedef enum logic {op_add = 1'b0, op_sub = 1'b1} op_e;

  // clock cycles from capture edge to ack rise
  localparam int unit_latency = 2;

endpackage

`default_nettype wire

//--- hw/unpacked_if.sv
// unpacked value bus with source and sink modports
`default_nettype none

interface unpacked_if import fp_pkg::*; ();

  logic nan;
  logic inf;
  logic zero;
  logic sign;
  // unbiased
  logic signed [uexp_w-1:0] exponent;
  logic [sig_w-1:0] significand;

  modport source (output nan, inf, zero, sign, exponent, significand);
  modport sink (input nan, inf, zero, sign, exponent, significand);

endinterface

`default_nettype wire

//--- hw/fp_unpack.sv
// binary32 classification and expansion to unpacked form
`default_nettype none

module fp_unpack import fp_pkg::*; (
  input  float_word_t       word,
  unpacked_if.source        u
);

  logic frac_nonzero;

  assign frac_nonzero = |word.fields.fraction;

  always_comb begin
    u.sign = word.fields.sign;
    u.nan = (word.fields.exponent == exp_special) && frac_nonzero;
    u.inf = (word.fields.exponent == exp_special) && !frac_nonzero;
    // subnormals count as zero
    u.zero = (word.fields.exponent == '0);
    if (u.zero) begin
      u.exponent = '0;
      u.significand = '0;
    end else begin
      u.exponent = uexp_w'($signed({{(uexp_w-exp_w){1'b0}}, word.fields.exponent}) - bias);
      u.significand = {1'b1, word.fields.fraction};
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_dual_path_add.sv
// near/far path add, normalisation, rne/rtz rounding, range checks
`default_nettype none

module fp_dual_path_add import fp_pkg::*, op_pkg::*; (
  input  op_e               op,
  input  round_mode_e       round_mode,
  unpacked_if.sink          a,
  unpacked_if.sink          b,
  unpacked_if.source        r
);

  logic a_larger;
  logic eff_sub;
  logic res_sign;
  logic signed [uexp_w-1:0] l_exp;
  logic signed [uexp_w-1:0] s_exp;
  logic [sig_w-1:0] l_sig;
  logic [sig_w-1:0] s_sig;
  logic [uexp_w-1:0] exp_diff;
  logic near_path;
  logic far_pass;
  logic [2*sig_w+3:0] s_shift;
  logic [sig_w+1:0] s_align;
  logic align_sticky;
  logic [sig_w+2:0] l_ext;
  logic [sig_w+2:0] s_ext;
  logic [sig_w+2:0] near_diff;
  logic [sig_w+2:0] far_sum;
  logic [4:0] lz;
  logic exact_zero;
  logic sticky_in;
  logic [sig_w+2:0] norm;
  logic signed [uexp_w-1:0] norm_exp;
  logic [sig_w-1:0] sig_trunc;
  logic guard;
  logic sticky;
  logic inc;
  logic [sig_w:0] sig_rnd;
  logic signed [uexp_w-1:0] rnd_exp;

  // leading zeros of the 26 bit near path difference
  function automatic logic [4:0] lead_zeros(input logic [sig_w+1:0] v);
    logic [4:0] n;
    logic found;
    n = '0;
    found = 1'b0;
    for (int i = sig_w + 1; i >= 0; i--) begin
      if (!found) begin
        if (v[i]) found = 1'b1;
        else n = n + 5'd1;
      end
    end
    return n;
  endfunction

  // order by exponent and then significand
  assign a_larger = (a.exponent > b.exponent) ||
                    ((a.exponent == b.exponent) && (a.significand > b.significand));
  assign eff_sub = a.sign ^ b.sign ^ (op == op_sub);
  assign res_sign = a_larger ? a.sign : (b.sign ^ (op == op_sub));
  assign l_exp = a_larger ? a.exponent : b.exponent;
  assign s_exp = a_larger ? b.exponent : a.exponent;
  assign l_sig = a_larger ? a.significand : b.significand;
  assign s_sig = a_larger ? b.significand : a.significand;
  assign exp_diff = l_exp - s_exp;

  assign near_path = eff_sub && (exp_diff <= 1);
  assign far_pass = (exp_diff > 26);

  // two extra low bits hold guard and round while shifted-out bits fold into sticky
  assign l_ext = {1'b0, l_sig, 2'b00};
  assign s_shift = {s_sig, 2'b00, {(sig_w+2){1'b0}}} >> exp_diff;
  assign s_align = s_shift[2*sig_w+3 -: sig_w+2];
  assign align_sticky = |s_shift[sig_w+1:0];
  assign s_ext = {1'b0, s_align};

  assign near_diff = l_ext - s_ext;
  // lost bits borrow one unit and keep sticky set
  assign far_sum = eff_sub ? (l_ext - s_ext - {{(sig_w+2){1'b0}}, align_sticky})
                           : (l_ext + s_ext);
  assign lz = lead_zeros(near_diff[sig_w+1:0]);

  always_comb begin
    exact_zero = 1'b0;
    sticky_in = align_sticky;
    norm = far_sum;
    norm_exp = l_exp;
    if (far_pass) begin
      norm = l_ext;
      sticky_in = 1'b0;
    end else if (near_path) begin
      // shift the cancelled difference up to the hidden bit
      exact_zero = (near_diff == '0);
      norm = near_diff << lz;
      norm_exp = l_exp - $signed({{(uexp_w-5){1'b0}}, lz});
    end else if (far_sum[sig_w+2]) begin
      norm = far_sum >> 1;
      sticky_in = far_sum[0] | align_sticky;
      norm_exp = l_exp + 1;
    end else if (!far_sum[sig_w+1]) begin
      norm = far_sum << 1;
      norm_exp = l_exp - 1;
    end
  end

  assign sig_trunc = norm[sig_w+1:2];
  assign guard = norm[1];
  assign sticky = norm[0] | sticky_in;
  assign inc = (round_mode == rne) && guard && (sticky || sig_trunc[0]);
  assign sig_rnd = {1'b0, sig_trunc} + {{sig_w{1'b0}}, inc};
  assign rnd_exp = sig_rnd[sig_w] ? norm_exp + 1 : norm_exp;

  always_comb begin
    r.nan = 1'b0;
    r.inf = 1'b0;
    r.zero = 1'b0;
    r.sign = res_sign;
    r.exponent = rnd_exp;
    r.significand = sig_rnd[sig_w] ? sig_rnd[sig_w:1] : sig_rnd[sig_w-1:0];
    if (exact_zero) begin
      // exact cancellation is +0
      r.zero = 1'b1;
      r.sign = 1'b0;
      r.exponent = '0;
      r.significand = '0;
    end else if (rnd_exp > emax) begin
      if (round_mode == rne) begin
        r.inf = 1'b1;
        r.exponent = '0;
        r.significand = '0;
      end else begin
        r.exponent = uexp_w'(emax);
        r.significand = '1;
      end
    end else if (rnd_exp < emin) begin
      // flush to signed zero
      r.zero = 1'b1;
      r.exponent = '0;
      r.significand = '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_special_select.sv
// NaN, infinity and zero rules ahead of the adder result
`default_nettype none

module fp_special_select import op_pkg::*; (
  input  op_e               op,
  unpacked_if.sink          a,
  unpacked_if.sink          b,
  unpacked_if.sink          dp,
  unpacked_if.source        r
);

  logic b_sign_eff;

  // b as it enters the sum
  assign b_sign_eff = b.sign ^ (op == op_sub);

  always_comb begin
    r.nan = 1'b0;
    r.inf = 1'b0;
    r.zero = 1'b0;
    r.sign = 1'b0;
    r.exponent = '0;
    r.significand = '0;
    if (a.nan || b.nan || (a.inf && b.inf && (a.sign != b_sign_eff))) begin
      r.nan = 1'b1;
    end else if (a.inf) begin
      r.inf = 1'b1;
      r.sign = a.sign;
    end else if (b.inf) begin
      r.inf = 1'b1;
      r.sign = b_sign_eff;
    end else if (a.zero && b.zero) begin
      r.zero = 1'b1;
      r.sign = a.sign & b_sign_eff;
    end else if (a.zero) begin
      r.sign = b_sign_eff;
      r.exponent = b.exponent;
      r.significand = b.significand;
    end else if (b.zero) begin
      r.sign = a.sign;
      r.exponent = a.exponent;
      r.significand = a.significand;
    end else begin
      r.nan = dp.nan;
      r.inf = dp.inf;
      r.zero = dp.zero;
      r.sign = dp.sign;
      r.exponent = dp.exponent;
      r.significand = dp.significand;
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_pack.sv
// unpacked value to binary32 encoding
`default_nettype none

module fp_pack import fp_pkg::*; (
  unpacked_if.sink          u,
  output float_word_t       word
);

  always_comb begin
    word.fields.sign = u.sign;
    word.fields.exponent = exp_w'(u.exponent + bias);
    // hidden bit dropped
    word.fields.fraction = u.significand[frac_w-1:0];
    if (u.nan) begin
      word.bits = qnan_word;
    end else if (u.inf) begin
      word.fields.exponent = exp_special;
      word.fields.fraction = '0;
    end else if (u.zero) begin
      word.fields.exponent = '0;
      word.fields.fraction = '0;
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_handshake.sv
// four-phase req/ack control with operand and result registers
`default_nettype none

module fp_handshake import op_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  output logic              ack,
  input  op_e               op,
  input  round_mode_e       round_mode,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  output op_e               op_q,
  output round_mode_e       mode_q,
  output logic [31:0]       a_q,
  output logic [31:0]       b_q,
  input  logic [31:0]       packed_result,
  output logic [31:0]       result
);

  // idle when neither busy nor ack, done while ack is high
  logic busy;
  logic [1:0] cnt;
  logic start;

  assign start = req && !ack && !busy;

  always_ff @(posedge clk) begin
    if (start) begin
      a_q <= a;
      b_q <= b;
      op_q <= op;
      mode_q <= round_mode;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      ack <= 1'b0;
      cnt <= '0;
      result <= '0;
    end else if (start) begin
      busy <= 1'b1;
      cnt <= '0;
    end else if (busy) begin
      cnt <= cnt + 2'd1;
      if (cnt == 2'(unit_latency - 1)) begin
        busy <= 1'b0;
        ack <= 1'b1;
        result <= packed_result;
      end
    end else if (ack && !req) begin
      // requester let go
      ack <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hw/fp_add_sub.sv
// binary32 add/subtract top level with req/ack handshake
`default_nettype none

module fp_add_sub import op_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              req,
  input  op_e               op,
  input  round_mode_e       round_mode,
  input  logic [31:0]       a,
  input  logic [31:0]       b,
  output logic              ack,
  output logic [31:0]       result
);

  op_e op_q;
  round_mode_e mode_q;
  logic [31:0] a_q;
  logic [31:0] b_q;
  logic [31:0] packed_result;

  unpacked_if a_if ();
  unpacked_if b_if ();
  unpacked_if dp_if ();
  unpacked_if res_if ();

  fp_handshake u_handshake (
    .clk(clk), .reset(reset), .req(req), .ack(ack),
    .op(op), .round_mode(round_mode), .a(a), .b(b),
    .op_q(op_q), .mode_q(mode_q), .a_q(a_q), .b_q(b_q),
    .packed_result(packed_result), .result(result)
  );

  fp_unpack u_unpack_a (.word(a_q), .u(a_if.source));
  fp_unpack u_unpack_b (.word(b_q), .u(b_if.source));

  fp_dual_path_add u_dual_path_add (
    .op(op_q), .round_mode(mode_q),
    .a(a_if.sink), .b(b_if.sink), .r(dp_if.source)
  );

  fp_special_select u_special_select (
    .op(op_q), .a(a_if.sink), .b(b_if.sink), .dp(dp_if.sink), .r(res_if.source)
  );

  fp_pack u_pack (.u(res_if.sink), .word(packed_result));

endmodule

`default_nettype wire

//--- tests/fp_add_sub_asserts.sv
// handshake assertions for fp_add_sub and their bind
`default_nettype none

module fp_add_sub_asserts import op_pkg::*; (
  input logic        clk,
  input logic        reset,
  input logic        req,
  input logic        ack,
  input logic [31:0] result
);

  a_reset_ack: assert property (@(posedge clk) reset |=> !ack)
    else $error("ack high after reset");

  // a new req in idle starts one operation
  a_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(req) && !ack |=> !ack [*unit_latency] ##1 ack)
    else $error("ack not raised unit_latency cycles after capture");

  a_rise_after_capture: assert property (@(posedge clk) disable iff (reset)
    $rose(ack) |-> $past(req && !ack, unit_latency + 1))
    else $error("ack rose without a capture");

  a_fall_after_req: assert property (@(posedge clk) disable iff (reset)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was high");

  a_result_stable: assert property (@(posedge clk) disable iff (reset)
    ack |=> (!ack || $stable(result)))
    else $error("result changed while ack high");

endmodule

bind fp_add_sub fp_add_sub_asserts u_asserts (.*);

`default_nettype wire

//--- tests/tb_fp_add_sub.sv
// testbench with clock, reset, reference model, directed and random stimulus and comparison
`default_nettype none

module tb_fp_add_sub import fp_pkg::*, op_pkg::*; ();

  logic clk;
  logic reset;
  logic req;
  op_e op;
  round_mode_e round_mode;
  logic [31:0] a;
  logic [31:0] b;
  logic ack;
  logic [31:0] result;

  logic [31:0] expected;
  logic [31:0] rng;
  logic ack_d = 1'b0;
  logic timed_out = 1'b0;
  int checks = 0;
  int mismatches = 0;
  int timeouts = 0;

  fp_add_sub u_fp_add_sub (
    .clk(clk), .reset(reset), .req(req), .op(op), .round_mode(round_mode),
    .a(a), .b(b), .ack(ack), .result(result)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  // exact sum of the two operands followed by one rounding step
  function automatic logic [31:0] ref_add(input op_e o, input round_mode_e m,
                                          input logic [31:0] x, input logic [31:0] y);
    float_word_t fa;
    float_word_t fb;
    logic sa;
    logic sb;
    logic sr;
    int ea;
    int eb;
    int base;
    int er;
    int p;
    int sh;
    longint ma;
    longint mb;
    longint sum;
    longint mag;
    longint sig;
    longint rem;
    longint half;
    fa.bits = x;
    fb.bits = y;
    sa = fa.fields.sign;
    sb = fb.fields.sign ^ (o == op_sub);
    ea = int'(fa.fields.exponent);
    eb = int'(fb.fields.exponent);
    if ((ea == 255 && fa.fields.fraction != 0) || (eb == 255 && fb.fields.fraction != 0))
      return qnan_word;
    if (ea == 255 && eb == 255 && sa != sb) return qnan_word;
    if (ea == 255) return {sa, exp_special, 23'h0};
    if (eb == 255) return {sb, exp_special, 23'h0};
    // exponent field 0 counts as zero including subnormals
    if (ea == 0 && eb == 0) return {sa & sb, 31'h0};
    if (ea == 0) return {sb, y[30:0]};
    if (eb == 0) return x;
    if (ea - eb > 26) return x;
    if (eb - ea > 26) return {sb, y[30:0]};
    base = (ea < eb) ? ea : eb;
    ma = {40'h0, 1'b1, fa.fields.fraction};
    mb = {40'h0, 1'b1, fb.fields.fraction};
    ma = ma << (ea - base);
    mb = mb << (eb - base);
    sum = (sa ? -ma : ma) + (sb ? -mb : mb);
    if (sum == 0) return 32'h0;
    sr = (sum < 0);
    mag = sr ? -sum : sum;
    p = 0;
    for (int i = 0; i < 62; i++) begin
      if (mag[i]) p = i;
    end
    er = base + p - 23;
    if (p > 23) begin
      sh = p - 23;
      sig = mag >> sh;
      rem = mag - (sig << sh);
      half = longint'(1) << (sh - 1);
      if (m == rne && (rem > half || (rem == half && sig[0]))) sig = sig + 1;
      if (sig[24]) begin
        sig = sig >> 1;
        er = er + 1;
      end
    end else begin
      sig = mag << (23 - p);
    end
    if (er > emax + bias) begin
      if (m == rne) return {sr, exp_special, 23'h0};
      return {sr, 8'hfe, 23'h7fffff};
    end
    if (er < emin + bias) return {sr, 31'h0};
    return {sr, 8'(er), sig[22:0]};
  endfunction

  // compare on each rising ack
  always @(negedge clk) begin
    ack_d <= ack;
    if (ack && !ack_d) begin
      checks++;
      if (result !== expected) begin
        mismatches++;
        $display("MISMATCH time %0t: a=%h b=%h op=%s mode=%s result=%h expected=%h",
                 $time, a, b, op.name(), round_mode.name(), result, expected);
      end
    end
  end

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (ack !== level && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (ack !== level) begin
      timeouts++;
      timed_out = 1'b1;
      $display("ERROR: time %0t, ack did not reach %0d within 20 cycles", $time, level);
    end
  endtask

  task automatic run_op(input op_e o, input round_mode_e m,
                        input logic [31:0] x, input logic [31:0] y);
    if (!timed_out) begin
      op = o;
      round_mode = m;
      a = x;
      b = y;
      expected = ref_add(o, m, x, y);
      req = 1'b1;
      wait_ack(1'b1);
      req = 1'b0;
      wait_ack(1'b0);
    end
  endtask

  // back-pressure followed by a watch for a spurious second ack
  task automatic hold_check(input logic [31:0] x, input logic [31:0] y);
    logic [31:0] held;
    if (!timed_out) begin
      op = op_add;
      round_mode = rne;
      a = x;
      b = y;
      expected = ref_add(op_add, rne, x, y);
      req = 1'b1;
      wait_ack(1'b1);
      held = result;
      repeat (10) begin
        @(negedge clk);
        if (ack !== 1'b1 || result !== held) begin
          mismatches++;
          $display("MISMATCH time %0t: ack=%b result=%h while req held, expected ack=1 result=%h",
                   $time, ack, result, held);
        end
      end
      req = 1'b0;
      wait_ack(1'b0);
      repeat (5) begin
        @(negedge clk);
        if (ack !== 1'b0) begin
          mismatches++;
          $display("MISMATCH time %0t: ack=1 without a new req", $time);
        end
      end
    end
  endtask

  initial begin
    logic [31:0] x;
    logic [31:0] y;
    logic [7:0] ex;
    reset = 1'b1;
    req = 1'b0;
    op = op_add;
    round_mode = rne;
    a = 32'h0;
    b = 32'h0;
    expected = 32'h0;
    rng = 32'd69;
    repeat (8) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    if (ack !== 1'b0 || result !== 32'h0) begin
      mismatches++;
      $display("MISMATCH time %0t: ack=%b result=%h after reset, expected 0 and 0",
               $time, ack, result);
    end
    // special values
    run_op(op_add, rne, 32'h7fc00000, 32'h3f800000);
    run_op(op_add, rne, 32'h3f800000, 32'h7f800001);
    run_op(op_sub, rne, 32'h7f800000, 32'h7f800000);
    run_op(op_add, rne, 32'h7f800000, 32'hff800000);
    run_op(op_add, rtz, 32'h7f800000, 32'h3f800000);
    run_op(op_sub, rne, 32'h3f800000, 32'h7f800000);
    run_op(op_add, rne, 32'hff800000, 32'h40a00000);
    // zeros and subnormals
    for (int s = 0; s < 8; s++) begin
      run_op(op_e'(s[2]), rne, {s[0], 31'h0}, {s[1], 31'h0});
    end
    run_op(op_add, rne, 32'h3fc00000, 32'h00000000);
    run_op(op_sub, rne, 32'h00000000, 32'h40490fdb);
    run_op(op_add, rne, 32'h00000001, 32'h3f800000);
    run_op(op_sub, rtz, 32'h80400000, 32'h00400000);
    // near path cancellation
    run_op(op_sub, rne, 32'h3f800000, 32'h3f800000);
    run_op(op_sub, rne, 32'h3f800001, 32'h3f800000);
    run_op(op_sub, rtz, 32'h40000000, 32'h3fffffff);
    run_op(op_add, rne, 32'h3f800000, 32'hbf7fffff);
    // overflow
    run_op(op_add, rne, 32'h7f7fffff, 32'h7f7fffff);
    run_op(op_add, rtz, 32'h7f7fffff, 32'h7f7fffff);
    run_op(op_add, rtz, 32'hff7fffff, 32'hff000000);
    // random normals with each pair run under both modes
    for (int i = 0; i < 200; i++) begin
      rng = xorshift(rng);
      ex = 8'(64 + rng % 127);
      rng = xorshift(rng);
      x = {rng[31], ex, rng[22:0]};
      rng = xorshift(rng);
      if (i % 4 == 0) begin
        y = {rng[31], ex - {7'h0, rng[0]}, x[22:8], rng[7:0]};
      end else begin
        y = {rng[31], 8'(64 + rng % 127), rng[22:0]};
      end
      run_op(op_e'(rng[30]), rne, x, y);
      run_op(op_e'(rng[30]), rtz, x, y);
    end
    hold_check(32'h3f800000, 32'h40000000);
    $display("checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
hw/fp_pkg.sv
hw/op_pkg.sv
hw/unpacked_if.sv
hw/fp_unpack.sv
hw/fp_dual_path_add.sv
hw/fp_special_select.sv
hw/fp_pack.sv
hw/fp_handshake.sv
hw/fp_add_sub.sv
tests/fp_add_sub_asserts.sv
tests/tb_fp_add_sub.sv

//--- Bender.yml
package:
  name: fp_add_sub

sources:
  - files:
      - hw/fp_pkg.sv
      - hw/op_pkg.sv
      - hw/unpacked_if.sv
      - hw/fp_unpack.sv
      - hw/fp_dual_path_add.sv
      - hw/fp_special_select.sv
      - hw/fp_pack.sv
      - hw/fp_handshake.sv
      - hw/fp_add_sub.sv
  - target: test
    files:
      - tests/fp_add_sub_asserts.sv
      - tests/tb_fp_add_sub.sv
